// File: rtl/titan_core_pkg.sv
package titan_core_pkg;

	// ##############################
	// Core data types
	// ##############################

	// Data or address word
	typedef logic [31:0] word_t;

	// Register file index
	typedef logic [4:0] reg_addr_t;

	// Load and store access size
	typedef enum logic [1:0] {
		MEM_BYTE = 2'd0,
		MEM_HALF = 2'd1,
		MEM_WORD = 2'd2
	} mem_size_e;

	// ##############################
	// Helpers
	// ##############################

	// Halfwords need bit 0 clear, words need both low bits clear
	function automatic logic mem_misaligned(mem_size_e size, logic [1:0] offset);
		logic mis;
		unique case (size)
			MEM_HALF: mis = offset[0];
			MEM_WORD: mis = |offset;
			default:  mis = 1'b0;
		endcase
		return mis;
	endfunction

endpackage

// File: rtl/titan_axi_pkg.sv
package titan_axi_pkg;

	// ##############################
	// AXI4-Lite fields
	// ##############################

	typedef logic [31:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;
	typedef logic [3:0]  axi_strb_t;
	typedef logic [1:0]  axi_resp_t;

	// Response codes
	localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
	localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;

endpackage

// File: rtl/titan_mem_stage.sv
`timescale 1ns/100ps

module titan_mem_stage (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	// Execute side
	input  logic                     ex_valid_i,
	input  titan_core_pkg::word_t     ex_pc_i,
	input  titan_core_pkg::word_t     ex_result_i,
	input  titan_core_pkg::word_t     ex_store_data_i,
	input  titan_core_pkg::reg_addr_t ex_waddr_i,
	input  logic                     ex_we_i,
	input  logic                     mem_read_i,
	input  logic                     mem_write_i,
	input  titan_core_pkg::mem_size_e mem_size_i,
	input  logic                     mem_unsigned_i,
	output logic                     ready_o,
	// Hazard unit
	input  logic                     stall_i,
	input  logic                     flush_i,
	// Load-store unit request
	output logic                     req_valid_o,
	output logic                     req_write_o,
	output titan_core_pkg::word_t     req_addr_o,
	output titan_core_pkg::word_t     req_wdata_o,
	output titan_core_pkg::mem_size_e req_size_o,
	output logic                     req_unsigned_o,
	input  logic                     req_ready_i,
	// Load-store unit response
	input  logic                     rsp_valid_i,
	input  titan_core_pkg::word_t     rsp_rdata_i,
	input  logic                     rsp_err_i,
	// To MEM/WB register
	output logic                     st_valid_o,
	output titan_core_pkg::word_t     st_pc_o,
	output titan_core_pkg::word_t     st_result_o,
	output titan_core_pkg::reg_addr_t st_waddr_o,
	output logic                     st_we_o,
	output logic                     st_load_misaligned_o,
	output logic                     st_store_misaligned_o,
	output logic                     st_load_fault_o,
	output logic                     st_store_fault_o
);
	import titan_core_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT,
		ST_HOLD
	} stage_state_e;

	stage_state_e state_q;
	logic         req_pend_q;
	logic         drop_q;
	logic         accept;
	logic         mis;
	logic         go_bus;

	word_t        store_q;
	logic         write_q;
	mem_size_e    size_q;
	logic         uns_q;

	assign ready_o = !stall_i && !flush_i && (state_q != ST_WAIT);
	assign accept  = ex_valid_i && ready_o;
	assign mis     = mem_misaligned(mem_size_i, ex_result_i[1:0]);
	assign go_bus  = (mem_read_i || mem_write_i) && !mis;

	// ##############################
	// Control
	// ##############################

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q    <= ST_IDLE;
			req_pend_q <= 1'b0;
			drop_q     <= 1'b0;
		end else begin
			if (req_valid_o && req_ready_i)
				req_pend_q <= 1'b0;
			unique case (state_q)
				ST_IDLE, ST_HOLD: begin
					if (flush_i) begin
						state_q <= ST_IDLE;
					end else if (accept) begin
						state_q    <= go_bus ? ST_WAIT : ST_HOLD;
						req_pend_q <= go_bus;
					end else if (state_q == ST_HOLD && !stall_i) begin
						state_q <= ST_IDLE;
					end
				end
				ST_WAIT: begin
					// Bus access runs to completion, result thrown away on flush
					if (flush_i)
						drop_q <= 1'b1;
					if (rsp_valid_i) begin
						state_q <= (drop_q || flush_i) ? ST_IDLE : ST_HOLD;
						drop_q  <= 1'b0;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// ##############################
	// Held instruction
	// ##############################

	always_ff @(posedge clk_i) begin
		if (accept) begin
			st_pc_o               <= ex_pc_i;
			st_result_o           <= ex_result_i;
			store_q               <= ex_store_data_i;
			st_waddr_o            <= ex_waddr_i;
			st_we_o               <= ex_we_i && !mem_write_i && !(mem_read_i && mis);
			write_q               <= mem_write_i;
			size_q                <= mem_size_i;
			uns_q                 <= mem_unsigned_i;
			st_load_misaligned_o  <= mem_read_i && mis;
			st_store_misaligned_o <= mem_write_i && mis;
			st_load_fault_o       <= 1'b0;
			st_store_fault_o      <= 1'b0;
		end else if (state_q == ST_WAIT && rsp_valid_i) begin
			// Stores and faulting loads keep the address as result
			if (!write_q && !rsp_err_i)
				st_result_o <= rsp_rdata_i;
			st_we_o          <= st_we_o && !rsp_err_i;
			st_load_fault_o  <= rsp_err_i && !write_q;
			st_store_fault_o <= rsp_err_i && write_q;
		end
	end

	assign req_valid_o    = (state_q == ST_WAIT) && req_pend_q;
	assign req_write_o    = write_q;
	assign req_addr_o     = st_result_o;
	assign req_wdata_o    = store_q;
	assign req_size_o     = size_q;
	assign req_unsigned_o = uns_q;

	assign st_valid_o = (state_q == ST_HOLD) && !stall_i && !flush_i;

endmodule

// File: rtl/titan_lsu.sv
`timescale 1ns/100ps

module titan_lsu (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	// Request from the stage
	input  logic                     req_valid_i,
	input  logic                     req_write_i,
	input  titan_core_pkg::word_t     req_addr_i,
	input  titan_core_pkg::word_t     req_wdata_i,
	input  titan_core_pkg::mem_size_e req_size_i,
	input  logic                     req_unsigned_i,
	output logic                     req_ready_o,
	// Response to the stage
	output logic                     rsp_valid_o,
	output titan_core_pkg::word_t     rsp_rdata_o,
	output logic                     rsp_err_o,
	// AXI4-Lite master
	output logic                     awvalid_o,
	input  logic                     awready_i,
	output titan_axi_pkg::axi_addr_t awaddr_o,
	output logic                     wvalid_o,
	input  logic                     wready_i,
	output titan_axi_pkg::axi_data_t wdata_o,
	output titan_axi_pkg::axi_strb_t wstrb_o,
	input  logic                     bvalid_i,
	input  titan_axi_pkg::axi_resp_t bresp_i,
	output logic                     bready_o,
	output logic                     arvalid_o,
	input  logic                     arready_i,
	output titan_axi_pkg::axi_addr_t araddr_o,
	input  logic                     rvalid_i,
	input  titan_axi_pkg::axi_data_t rdata_i,
	input  titan_axi_pkg::axi_resp_t rresp_i,
	output logic                     rready_o
);
	import titan_core_pkg::*;
	import titan_axi_pkg::*;

	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_WADDR,
		LSU_WRESP,
		LSU_READ
	} lsu_state_e;

	lsu_state_e state_q;
	logic       awvalid_q;
	logic       wvalid_q;
	logic       arvalid_q;

	axi_addr_t  addr_q;
	axi_data_t  wdata_q;
	axi_strb_t  strb_q;
	logic [1:0] off_q;
	mem_size_e  size_q;
	logic       uns_q;

	axi_data_t  lane_wdata;
	axi_strb_t  lane_strb;
	axi_data_t  lane_rdata;

	// ##############################
	// Store lane placement
	// ##############################

	always_comb begin
		unique case (req_size_i)
			MEM_BYTE: begin
				lane_wdata = {4{req_wdata_i[7:0]}};
				lane_strb  = 4'b0001 << req_addr_i[1:0];
			end
			MEM_HALF: begin
				lane_wdata = {2{req_wdata_i[15:0]}};
				lane_strb  = 4'b0011 << req_addr_i[1:0];
			end
			default: begin
				lane_wdata = req_wdata_i;
				lane_strb  = 4'b1111;
			end
		endcase
	end

	// ##############################
	// Bus FSM
	// ##############################

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q   <= LSU_IDLE;
			awvalid_q <= 1'b0;
			wvalid_q  <= 1'b0;
			arvalid_q <= 1'b0;
		end else begin
			unique case (state_q)
				LSU_IDLE: begin
					if (req_valid_i && req_write_i) begin
						state_q   <= LSU_WADDR;
						awvalid_q <= 1'b1;
						wvalid_q  <= 1'b1;
					end else if (req_valid_i) begin
						state_q   <= LSU_READ;
						arvalid_q <= 1'b1;
					end
				end
				LSU_WADDR: begin
					// aw and w may be taken in different cycles
					if (awready_i)
						awvalid_q <= 1'b0;
					if (wready_i)
						wvalid_q <= 1'b0;
					if ((awready_i || !awvalid_q) && (wready_i || !wvalid_q))
						state_q <= LSU_WRESP;
				end
				LSU_WRESP: begin
					if (bvalid_i)
						state_q <= LSU_IDLE;
				end
				LSU_READ: begin
					if (arready_i)
						arvalid_q <= 1'b0;
					if (rvalid_i)
						state_q <= LSU_IDLE;
				end
				default: state_q <= LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == LSU_IDLE && req_valid_i) begin
			addr_q  <= {req_addr_i[31:2], 2'b00};
			wdata_q <= lane_wdata;
			strb_q  <= lane_strb;
			off_q   <= req_addr_i[1:0];
			size_q  <= req_size_i;
			uns_q   <= req_unsigned_i;
		end
	end

	// ##############################
	// Load extension
	// ##############################

	always_comb begin
		lane_rdata = rdata_i >> {off_q, 3'b000};
		unique case (size_q)
			MEM_BYTE: rsp_rdata_o = uns_q ? {24'h0, lane_rdata[7:0]}
			                               : {{24{lane_rdata[7]}}, lane_rdata[7:0]};
			MEM_HALF: rsp_rdata_o = uns_q ? {16'h0, lane_rdata[15:0]}
			                               : {{16{lane_rdata[15]}}, lane_rdata[15:0]};
			default:  rsp_rdata_o = lane_rdata;
		endcase
	end

	assign req_ready_o = (state_q == LSU_IDLE);
	assign rsp_valid_o = (state_q == LSU_WRESP && bvalid_i) || (state_q == LSU_READ && rvalid_i);
	assign rsp_err_o   = (state_q == LSU_READ) ? (rresp_i != AXI_RESP_OKAY)
	                                           : (bresp_i != AXI_RESP_OKAY);

	assign awvalid_o = awvalid_q;
	assign awaddr_o  = addr_q;
	assign wvalid_o  = wvalid_q;
	assign wdata_o   = wdata_q;
	assign wstrb_o   = strb_q;
	assign bready_o  = 1'b1;
	assign arvalid_o = arvalid_q;
	assign araddr_o  = addr_q;
	assign rready_o  = 1'b1;

endmodule

// File: rtl/titan_dmem.sv
`timescale 1ns/100ps

module titan_dmem #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	// Write address and data
	input  logic                     awvalid_i,
	output logic                     awready_o,
	input  titan_axi_pkg::axi_addr_t awaddr_i,
	input  logic                     wvalid_i,
	output logic                     wready_o,
	input  titan_axi_pkg::axi_data_t wdata_i,
	input  titan_axi_pkg::axi_strb_t wstrb_i,
	// Write response
	output logic                     bvalid_o,
	output titan_axi_pkg::axi_resp_t bresp_o,
	input  logic                     bready_i,
	// Read
	input  logic                     arvalid_i,
	output logic                     arready_o,
	input  titan_axi_pkg::axi_addr_t araddr_i,
	output logic                     rvalid_o,
	output titan_axi_pkg::axi_data_t rdata_o,
	output titan_axi_pkg::axi_resp_t rresp_o,
	input  logic                     rready_i
);
	import titan_axi_pkg::*;

	localparam int IDX_W = $clog2(DMEM_WORDS);

	axi_data_t mem_q [DMEM_WORDS];

	logic wait_q;
	logic busy;
	logic wr_go;
	logic rd_go;
	logic wr_hit;
	logic rd_hit;

	assign busy = bvalid_o || rvalid_o;

	// Every request sits one cycle before it is taken
	assign wr_go = !busy && wait_q && awvalid_i && wvalid_i;
	assign rd_go = !busy && wait_q && arvalid_i && !awvalid_i;

	assign awready_o = wr_go;
	assign wready_o  = wr_go;
	assign arready_o = rd_go;

	// Word index past the RAM depth
	assign wr_hit = (awaddr_i[31:IDX_W+2] == '0);
	assign rd_hit = (araddr_i[31:IDX_W+2] == '0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wait_q   <= 1'b0;
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			wait_q <= !busy && !wait_q && ((awvalid_i && wvalid_i) || arvalid_i);
			if (wr_go)
				bvalid_o <= 1'b1;
			else if (bready_i)
				bvalid_o <= 1'b0;
			if (rd_go)
				rvalid_o <= 1'b1;
			else if (rready_i)
				rvalid_o <= 1'b0;
		end
	end

	// ##############################
	// Storage
	// ##############################

	always_ff @(posedge clk_i) begin
		if (wr_go) begin
			bresp_o <= wr_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
			if (wr_hit) begin
				for (int i = 0; i < 4; i++) begin
					if (wstrb_i[i])
						mem_q[awaddr_i[IDX_W+1:2]][8*i +: 8] <= wdata_i[8*i +: 8];
				end
			end
		end
		if (rd_go) begin
			rdata_o <= rd_hit ? mem_q[araddr_i[IDX_W+1:2]] : '0;
			rresp_o <= rd_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
		end
	end

endmodule

// File: rtl/titan_wb_stage.sv
`timescale 1ns/100ps

module titan_wb_stage (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     stall_i,
	input  logic                     flush_i,
	// From the memory stage
	input  logic                     st_valid_i,
	input  titan_core_pkg::word_t     st_pc_i,
	input  titan_core_pkg::word_t     st_result_i,
	input  titan_core_pkg::reg_addr_t st_waddr_i,
	input  logic                     st_we_i,
	input  logic                     st_load_misaligned_i,
	input  logic                     st_store_misaligned_i,
	input  logic                     st_load_fault_i,
	input  logic                     st_store_fault_i,
	// Writeback
	output logic                     wb_valid_o,
	output titan_core_pkg::word_t     wb_pc_o,
	output titan_core_pkg::word_t     wb_result_o,
	output titan_core_pkg::reg_addr_t wb_waddr_o,
	output logic                     wb_we_o,
	output logic                     wb_load_misaligned_o,
	output logic                     wb_store_misaligned_o,
	output logic                     wb_load_fault_o,
	output logic                     wb_store_fault_o
);

	logic load_en;

	assign load_en = !flush_i && !stall_i;

	// Flush empties the slot, a writeback lasts one cycle
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_valid_o            <= 1'b0;
			wb_we_o               <= 1'b0;
			wb_load_misaligned_o  <= 1'b0;
			wb_store_misaligned_o <= 1'b0;
			wb_load_fault_o       <= 1'b0;
			wb_store_fault_o      <= 1'b0;
		end else if (flush_i || (load_en && !st_valid_i)) begin
			wb_valid_o            <= 1'b0;
			wb_we_o               <= 1'b0;
			wb_load_misaligned_o  <= 1'b0;
			wb_store_misaligned_o <= 1'b0;
			wb_load_fault_o       <= 1'b0;
			wb_store_fault_o      <= 1'b0;
		end else if (load_en) begin
			wb_valid_o            <= 1'b1;
			wb_we_o               <= st_we_i;
			wb_load_misaligned_o  <= st_load_misaligned_i;
			wb_store_misaligned_o <= st_store_misaligned_i;
			wb_load_fault_o       <= st_load_fault_i;
			wb_store_fault_o      <= st_store_fault_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load_en && st_valid_i) begin
			wb_pc_o     <= st_pc_i;
			wb_result_o <= st_result_i;
			wb_waddr_o  <= st_waddr_i;
		end
	end

endmodule

// File: rtl/titan_mem_top.sv
`timescale 1ns/100ps

module titan_mem_top #(
	parameter int DMEM_WORDS = 256
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic                     ex_valid_i,
	input  titan_core_pkg::word_t     ex_pc_i,
	input  titan_core_pkg::word_t     ex_result_i,
	input  titan_core_pkg::word_t     ex_store_data_i,
	input  titan_core_pkg::reg_addr_t ex_waddr_i,
	input  logic                     ex_we_i,
	input  logic                     mem_read_i,
	input  logic                     mem_write_i,
	input  titan_core_pkg::mem_size_e mem_size_i,
	input  logic                     mem_unsigned_i,
	output logic                     ready_o,
	input  logic                     stall_i,
	input  logic                     flush_i,
	output logic                     wb_valid_o,
	output titan_core_pkg::word_t     wb_pc_o,
	output titan_core_pkg::word_t     wb_result_o,
	output titan_core_pkg::reg_addr_t wb_waddr_o,
	output logic                     wb_we_o,
	output logic                     wb_load_misaligned_o,
	output logic                     wb_store_misaligned_o,
	output logic                     wb_load_fault_o,
	output logic                     wb_store_fault_o
);
	import titan_core_pkg::*;
	import titan_axi_pkg::*;

	// Stage to load-store unit
	logic      req_valid, req_write, req_unsigned, req_ready;
	word_t     req_addr, req_wdata;
	mem_size_e req_size;
	logic      rsp_valid, rsp_err;
	word_t     rsp_rdata;

	// Stage to MEM/WB register
	logic      st_valid, st_we;
	word_t     st_pc, st_result;
	reg_addr_t st_waddr;
	logic      st_load_misaligned, st_store_misaligned;
	logic      st_load_fault, st_store_fault;

	// AXI4-Lite
	logic      awvalid, awready, wvalid, wready, bvalid, bready;
	logic      arvalid, arready, rvalid, rready;
	axi_addr_t awaddr, araddr;
	axi_data_t wdata, rdata;
	axi_strb_t wstrb;
	axi_resp_t bresp, rresp;

	titan_mem_stage u_mem_stage (
		.clk_i                 (clk_i),
		.rst_n_i               (rst_n_i),
		.ex_valid_i            (ex_valid_i),
		.ex_pc_i               (ex_pc_i),
		.ex_result_i           (ex_result_i),
		.ex_store_data_i       (ex_store_data_i),
		.ex_waddr_i            (ex_waddr_i),
		.ex_we_i               (ex_we_i),
		.mem_read_i            (mem_read_i),
		.mem_write_i           (mem_write_i),
		.mem_size_i            (mem_size_i),
		.mem_unsigned_i        (mem_unsigned_i),
		.ready_o               (ready_o),
		.stall_i               (stall_i),
		.flush_i               (flush_i),
		.req_valid_o           (req_valid),
		.req_write_o           (req_write),
		.req_addr_o            (req_addr),
		.req_wdata_o           (req_wdata),
		.req_size_o            (req_size),
		.req_unsigned_o        (req_unsigned),
		.req_ready_i           (req_ready),
		.rsp_valid_i           (rsp_valid),
		.rsp_rdata_i           (rsp_rdata),
		.rsp_err_i             (rsp_err),
		.st_valid_o            (st_valid),
		.st_pc_o               (st_pc),
		.st_result_o           (st_result),
		.st_waddr_o            (st_waddr),
		.st_we_o               (st_we),
		.st_load_misaligned_o  (st_load_misaligned),
		.st_store_misaligned_o (st_store_misaligned),
		.st_load_fault_o       (st_load_fault),
		.st_store_fault_o      (st_store_fault)
	);

	titan_lsu u_lsu (
		.clk_i          (clk_i),
		.rst_n_i        (rst_n_i),
		.req_valid_i    (req_valid),
		.req_write_i    (req_write),
		.req_addr_i     (req_addr),
		.req_wdata_i    (req_wdata),
		.req_size_i     (req_size),
		.req_unsigned_i (req_unsigned),
		.req_ready_o    (req_ready),
		.rsp_valid_o    (rsp_valid),
		.rsp_rdata_o    (rsp_rdata),
		.rsp_err_o      (rsp_err),
		.awvalid_o      (awvalid),
		.awready_i      (awready),
		.awaddr_o       (awaddr),
		.wvalid_o       (wvalid),
		.wready_i       (wready),
		.wdata_o        (wdata),
		.wstrb_o        (wstrb),
		.bvalid_i       (bvalid),
		.bresp_i        (bresp),
		.bready_o       (bready),
		.arvalid_o      (arvalid),
		.arready_i      (arready),
		.araddr_o       (araddr),
		.rvalid_i       (rvalid),
		.rdata_i        (rdata),
		.rresp_i        (rresp),
		.rready_o       (rready)
	);

	titan_dmem #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_dmem (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.awaddr_i  (awaddr),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.bvalid_o  (bvalid),
		.bresp_o   (bresp),
		.bready_i  (bready),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.araddr_i  (araddr),
		.rvalid_o  (rvalid),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rready_i  (rready)
	);

	titan_wb_stage u_wb_stage (
		.clk_i                 (clk_i),
		.rst_n_i               (rst_n_i),
		.stall_i               (stall_i),
		.flush_i               (flush_i),
		.st_valid_i            (st_valid),
		.st_pc_i               (st_pc),
		.st_result_i           (st_result),
		.st_waddr_i            (st_waddr),
		.st_we_i               (st_we),
		.st_load_misaligned_i  (st_load_misaligned),
		.st_store_misaligned_i (st_store_misaligned),
		.st_load_fault_i       (st_load_fault),
		.st_store_fault_i      (st_store_fault),
		.wb_valid_o            (wb_valid_o),
		.wb_pc_o               (wb_pc_o),
		.wb_result_o           (wb_result_o),
		.wb_waddr_o            (wb_waddr_o),
		.wb_we_o               (wb_we_o),
		.wb_load_misaligned_o  (wb_load_misaligned_o),
		.wb_store_misaligned_o (wb_store_misaligned_o),
		.wb_load_fault_o       (wb_load_fault_o),
		.wb_store_fault_o      (wb_store_fault_o)
	);

endmodule

// File: test/titan_mem_chk.sv
`timescale 1ns/100ps

module titan_mem_chk (
	input logic                     clk_i,
	input logic                     rst_n_i,
	input logic                     awvalid_i,
	input logic                     awready_i,
	input titan_axi_pkg::axi_addr_t awaddr_i,
	input logic                     wvalid_i,
	input logic                     arvalid_i,
	input logic                     arready_i,
	input titan_axi_pkg::axi_addr_t araddr_i,
	input logic                     lsu_busy_i,
	input logic                     ready_i
);

	int fail_cnt = 0;

	// ##############################
	// AXI4-Lite master side
	// ##############################

	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
		else begin
			$error("awvalid dropped or awaddr moved before awready");
			fail_cnt++;
		end

	ar_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
		else begin
			$error("arvalid dropped or araddr moved before arready");
			fail_cnt++;
		end

	// Reads and writes never overlap
	one_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!((awvalid_i || wvalid_i) && arvalid_i))
		else begin
			$error("read and write requested at once");
			fail_cnt++;
		end

	busy_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		lsu_busy_i |-> !ready_i)
		else begin
			$error("ready_o high while a bus access is outstanding");
			fail_cnt++;
		end

endmodule

bind titan_mem_top titan_mem_chk u_chk (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.awvalid_i  (u_lsu.awvalid_o),
	.awready_i  (u_lsu.awready_i),
	.awaddr_i   (u_lsu.awaddr_o),
	.wvalid_i   (u_lsu.wvalid_o),
	.arvalid_i  (u_lsu.arvalid_o),
	.arready_i  (u_lsu.arready_i),
	.araddr_i   (u_lsu.araddr_o),
	.lsu_busy_i (!u_lsu.req_ready_o),
	.ready_i    (ready_o)
);

// File: test/titan_mem_tb.sv
`timescale 1ns/100ps

module titan_mem_tb;
	import titan_core_pkg::*;

	localparam int DMEM_WORDS = 256;
	localparam int MAX_LINES  = 64;

	logic      clk_i;
	logic      rst_n_i;
	logic      ex_valid_i;
	word_t     ex_pc_i;
	word_t     ex_result_i;
	word_t     ex_store_data_i;
	reg_addr_t ex_waddr_i;
	logic      ex_we_i;
	logic      mem_read_i;
	logic      mem_write_i;
	mem_size_e mem_size_i;
	logic      mem_unsigned_i;
	logic      ready_o;
	logic      stall_i;
	logic      flush_i;
	logic      wb_valid_o;
	word_t     wb_pc_o;
	word_t     wb_result_o;
	reg_addr_t wb_waddr_o;
	logic      wb_we_o;
	logic      wb_load_misaligned_o;
	logic      wb_store_misaligned_o;
	logic      wb_load_fault_o;
	logic      wb_store_fault_o;

	// Golden table, one entry per instruction
	logic [7:0]  op_a    [MAX_LINES];
	logic [1:0]  size_a  [MAX_LINES];
	logic        uns_a   [MAX_LINES];
	logic [31:0] addr_a  [MAX_LINES];
	logic [31:0] data_a  [MAX_LINES];
	logic [4:0]  waddr_a [MAX_LINES];
	logic [31:0] res_a   [MAX_LINES];
	logic        we_a    [MAX_LINES];
	logic [3:0]  flag_a  [MAX_LINES];

	int n_lines  = 0;
	int n_checks = 0;
	int n_errors = 0;
	int cycles   = 0;
	int limit    = 200;

	titan_mem_top #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_titan_mem_top (
		.clk_i                 (clk_i),
		.rst_n_i               (rst_n_i),
		.ex_valid_i            (ex_valid_i),
		.ex_pc_i               (ex_pc_i),
		.ex_result_i           (ex_result_i),
		.ex_store_data_i       (ex_store_data_i),
		.ex_waddr_i            (ex_waddr_i),
		.ex_we_i               (ex_we_i),
		.mem_read_i            (mem_read_i),
		.mem_write_i           (mem_write_i),
		.mem_size_i            (mem_size_i),
		.mem_unsigned_i        (mem_unsigned_i),
		.ready_o               (ready_o),
		.stall_i               (stall_i),
		.flush_i               (flush_i),
		.wb_valid_o            (wb_valid_o),
		.wb_pc_o               (wb_pc_o),
		.wb_result_o           (wb_result_o),
		.wb_waddr_o            (wb_waddr_o),
		.wb_we_o               (wb_we_o),
		.wb_load_misaligned_o  (wb_load_misaligned_o),
		.wb_store_misaligned_o (wb_store_misaligned_o),
		.wb_load_fault_o       (wb_load_fault_o),
		.wb_store_fault_o      (wb_store_fault_o)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: no progress after %0d cycles", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// ##############################
	// Helpers
	// ##############################

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic load_golden();
		int          fd;
		int          n;
		int          sz;
		int          un;
		int          we;
		logic [7:0]  opc;
		logic [31:0] ad;
		logic [31:0] dt;
		logic [31:0] wa;
		logic [31:0] rs;
		logic [3:0]  fl;
		string       line;
		fd = $fopen("test/titan_mem_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the golden file");
			n_errors++;
		end else begin
			while (!$feof(fd) && n_lines < MAX_LINES) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%c %d %d %h %h %h %h %d %b",
					            opc, sz, un, ad, dt, wa, rs, we, fl);
					if (n != 9) begin
						$display("Malformed golden line: %s", line);
						n_errors++;
					end else begin
						op_a[n_lines]    = opc;
						size_a[n_lines]  = sz[1:0];
						uns_a[n_lines]   = un[0];
						addr_a[n_lines]  = ad;
						data_a[n_lines]  = dt;
						waddr_a[n_lines] = wa[4:0];
						res_a[n_lines]   = rs;
						we_a[n_lines]    = we[0];
						flag_a[n_lines]  = fl;
						n_lines++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Present one instruction and hold it until the stage takes it
	task automatic issue(input int i);
		@(negedge clk_i);
		ex_pc_i         = 32'h1000 + 4 * i;
		ex_result_i     = addr_a[i];
		ex_store_data_i = data_a[i];
		ex_waddr_i      = waddr_a[i];
		mem_write_i     = (op_a[i] == "S");
		mem_read_i      = (op_a[i] == "L") || (op_a[i] == "T") || (op_a[i] == "F");
		ex_we_i         = (op_a[i] == "N") ? we_a[i] : !mem_write_i;
		mem_size_i      = mem_size_e'(size_a[i]);
		mem_unsigned_i  = uns_a[i];
		ex_valid_i      = 1'b1;
		while (!ready_o)
			@(negedge clk_i);
		@(posedge clk_i);
		@(negedge clk_i);
		ex_valid_i = 1'b0;
	endtask

	task automatic wait_writeback(output int lat);
		lat = 0;
		while (!wb_valid_o) begin
			@(negedge clk_i);
			lat++;
		end
	endtask

	task automatic compare_writeback(input int i);
		check("wb_pc_o", wb_pc_o, 32'h1000 + 4 * i);
		check("wb_result_o", wb_result_o, res_a[i]);
		check("wb_waddr_o", wb_waddr_o, waddr_a[i]);
		check("wb_we_o", wb_we_o, we_a[i]);
		check("exception flags", {wb_load_misaligned_o, wb_store_misaligned_o,
		      wb_load_fault_o, wb_store_fault_o}, flag_a[i]);
	endtask

	// ##############################
	// Main sequence
	// ##############################

	initial begin
		int lat;
		int errs_before;
		clk_i           = 1'b0;
		rst_n_i         = 1'b0;
		ex_valid_i      = 1'b0;
		ex_pc_i         = '0;
		ex_result_i     = '0;
		ex_store_data_i = '0;
		ex_waddr_i      = '0;
		ex_we_i         = 1'b0;
		mem_read_i      = 1'b0;
		mem_write_i     = 1'b0;
		mem_size_i      = MEM_WORD;
		mem_unsigned_i  = 1'b0;
		stall_i         = 1'b0;
		flush_i         = 1'b0;

		load_golden();
		limit = n_lines * 40 + 200;
		if (n_lines == 0) begin
			$display("The golden file holds no tests");
			n_errors++;
		end

		repeat (16) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		check("ready_o after reset", ready_o, 1'b1);
		check("wb_valid_o after reset", wb_valid_o, 1'b0);

		for (int i = 0; i < n_lines; i++) begin
			errs_before = n_errors;
			issue(i);
			if (op_a[i] == "T") begin
				// The load completes under stall and waits in the stage
				stall_i = 1'b1;
				repeat (8) begin
					@(negedge clk_i);
					check("ready_o under stall", ready_o, 1'b0);
					check("wb_valid_o under stall", wb_valid_o, 1'b0);
				end
				stall_i = 1'b0;
			end else if (op_a[i] == "F") begin
				flush_i = 1'b1;
				@(negedge clk_i);
				flush_i = 1'b0;
				repeat (12) begin
					@(negedge clk_i);
					check("wb_valid_o after flush", wb_valid_o, 1'b0);
					check("wb_we_o after flush", wb_we_o, we_a[i]);
				end
				check("ready_o after flush", ready_o, 1'b1);
			end
			if (op_a[i] != "F") begin
				wait_writeback(lat);
				compare_writeback(i);
				// A result parked under stall leaves one cycle after the stall ends
				if (op_a[i] == "N" || op_a[i] == "T" || flag_a[i][3:2] != 2'b00)
					check("writeback latency", lat, 1);
			end
			if (op_a[i] == "T") begin
				// A valid entry must hold while stalled
				stall_i = 1'b1;
				repeat (3) begin
					@(negedge clk_i);
					check("wb_valid_o held", wb_valid_o, 1'b1);
					check("wb_result_o held", wb_result_o, res_a[i]);
					check("ready_o held low", ready_o, 1'b0);
				end
				stall_i = 1'b0;
				@(negedge clk_i);
				check("wb_valid_o after stall", wb_valid_o, 1'b0);
			end
			$display("test %0d (%c): %s", i, op_a[i],
			         (n_errors == errs_before) ? "ok" : "mismatch");
		end

		n_errors += u_titan_mem_top.u_chk.fail_cnt;
		$display("%0d tests, %0d checks, %0d errors", n_lines, n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: test/titan_mem_golden.txt
# op size uns addr_or_result store_data waddr exp_result exp_we exp_flags(lm sm lf sf)
# op L load, S store, N non-memory, T stall and F flush carry a load; size 0 byte 1 half 2 word
S 2 0 00000010 12345678 00 00000010 0 0000
S 2 0 00000014 cafef00d 00 00000014 0 0000
S 2 0 00000000 0badf00d 00 00000000 0 0000
L 2 0 00000010 00000000 05 12345678 1 0000
L 2 0 00000014 00000000 06 cafef00d 1 0000
S 2 0 00000020 11223344 00 00000020 0 0000
S 0 0 00000021 000000a5 00 00000021 0 0000
S 1 0 00000022 0000beef 00 00000022 0 0000
L 2 0 00000020 00000000 07 beefa544 1 0000
L 0 0 00000021 00000000 08 ffffffa5 1 0000
L 0 1 00000021 00000000 09 000000a5 1 0000
L 1 0 00000022 00000000 0a ffffbeef 1 0000
L 1 1 00000022 00000000 0b 0000beef 1 0000
L 0 0 00000020 00000000 0c 00000044 1 0000
S 1 0 00000013 0000ffff 00 00000013 0 0100
L 2 0 00000012 00000000 0d 00000012 0 1000
S 2 0 00000011 ffffffff 00 00000011 0 0100
L 2 0 00000010 00000000 0e 12345678 1 0000
S 2 0 00000400 deadbeef 00 00000400 0 0001
L 0 1 000007fd 00000000 0f 000007fd 0 0010
L 2 0 00000000 00000000 10 0badf00d 1 0000
N 0 0 a5a5a5a5 00000000 1f a5a5a5a5 1 0000
N 0 0 00000abc 00000000 03 00000abc 0 0000
T 2 0 00000014 00000000 11 cafef00d 1 0000
F 2 0 00000010 00000000 12 00000000 0 0000

// File: flist.f
rtl/titan_core_pkg.sv
rtl/titan_axi_pkg.sv
rtl/titan_mem_stage.sv
rtl/titan_lsu.sv
rtl/titan_dmem.sv
rtl/titan_wb_stage.sv
rtl/titan_mem_top.sv
test/titan_mem_chk.sv
test/titan_mem_tb.sv

// File: Bender.yml
package:
  name: titan_mem

sources:
  - files:
      - rtl/titan_core_pkg.sv
      - rtl/titan_axi_pkg.sv
      - rtl/titan_mem_stage.sv
      - rtl/titan_lsu.sv
      - rtl/titan_dmem.sv
      - rtl/titan_wb_stage.sv
      - rtl/titan_mem_top.sv
  - target: test
    files:
      - test/titan_mem_chk.sv
      - test/titan_mem_tb.sv
